// File: src/cpu_config.svh
/* CPU configuration
   Data width, register count, reset PC and the NOP encoding */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and register file sizes
`define CPU_XLEN   32
`define CPU_NREGS  32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// addi x0, x0, 0 fills flushed slots
`define CPU_NOP 32'h0000_0013

`endif

// File: src/rv32i_isa_pkg.sv
/* RV32I instruction-set definitions
   Opcodes, funct values and the instruction formats as one decoded word */
`include "cpu_config.svh"

package rv32i_isa_pkg;

  typedef enum logic [6:0] {
    OP_R       = 7'b0110011,
    OP_I_ARITH = 7'b0010011,
    OP_LOAD    = 7'b0000011,
    OP_STORE   = 7'b0100011,
    OP_BRANCH  = 7'b1100011,
    OP_LUI     = 7'b0110111,
    OP_JAL     = 7'b1101111
  } opcode_e;

  // Field layouts from the MSB down
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  localparam instr_u NOP_INSTR = `CPU_NOP;

  // ALU funct3 / funct7
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

// File: src/pipe_pkg.sv
/* Pipeline types
   Control bundle, ALU types and the four stage register layouts */
`include "cpu_config.svh"

package pipe_pkg;
  import rv32i_isa_pkg::*;

  typedef logic [`CPU_XLEN-1:0]         word_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

  localparam word_t RESET_PC = `CPU_RESET_PC;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL
  } alu_op_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } alu_flags_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_to_reg;
    logic    mem_write;
    logic    alu_src;    // Operand b from immediate
    logic    store_imm;  // S-format immediate
    logic    branch;
    logic    jal;
    logic    lui;        // Operand a forced to zero
    alu_op_e alu_op;
  } ctrl_t;

  typedef enum logic [1:0] {
    FWD_NONE, FWD_MEM, FWD_WB
  } fwd_sel_e;

  typedef struct packed {
    word_t  pc;
    instr_u instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t      ctrl;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    word_t      pc;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rd;
    word_t    alu_result;
    word_t    store_data;
    word_t    pc;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rd;
    word_t    alu_result;
    word_t    rdata;
    word_t    pc;
  } mem_wb_t;

endpackage

// File: src/decoder.sv
/* Instruction decoder
   Control bundle, ALU operation and sign-extended immediate for one instruction */
`timescale 1ns/1ps

module decoder
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;
(
  input  instr_u instr,
  output ctrl_t  ctrl,
  output word_t  imm
);

  alu_op_e r_op;
  alu_op_e i_op;
  word_t   i_imm;
  word_t   s_imm;
  word_t   b_imm;
  word_t   u_imm;
  word_t   j_imm;

  // Sub needs funct7 in register-register ops
  always_comb begin
    case (instr.r.funct3)
      F3_ADD:  r_op = (instr.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
      F3_SLL:  r_op = ALU_SLL;
      F3_XOR:  r_op = ALU_XOR;
      F3_OR:   r_op = ALU_OR;
      F3_AND:  r_op = ALU_AND;
      default: r_op = ALU_ADD;
    endcase
  end

  always_comb begin
    case (instr.i.funct3)
      F3_SLL:  i_op = ALU_SLL;
      F3_XOR:  i_op = ALU_XOR;
      F3_OR:   i_op = ALU_OR;
      F3_AND:  i_op = ALU_AND;
      default: i_op = ALU_ADD;
    endcase
  end

  always_comb begin
    ctrl = '0;  // Unknown opcode leaves everything clear
    case (instr.r.opcode)
      OP_R: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = r_op;
      end
      OP_I_ARITH: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = i_op;
      end
      OP_LOAD: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.store_imm = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;  // Flags drive the compare
      end
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.lui       = 1'b1;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

  assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign s_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign u_imm = {instr.u.imm31_12, 12'b0};
  assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};

  // Format follows from the decoded bundle
  always_comb begin
    if (ctrl.lui)
      imm = u_imm;
    else if (ctrl.jal)
      imm = j_imm;
    else if (ctrl.branch)
      imm = b_imm;
    else if (ctrl.store_imm)
      imm = s_imm;
    else
      imm = i_imm;
  end

endmodule

// File: src/regfile.sv
/* Register file
   x1 to x31 with x0 tied to zero and a same-cycle write bypass */
`timescale 1ns/1ps
`include "cpu_config.svh"

module regfile
  import pipe_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     we,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [1:`CPU_NREGS-1];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 1; i < `CPU_NREGS; i++)
        regs[i] <= '0;
    end
    else if (we && rd != '0)
      regs[rd] <= rd_data;
  end

  // Write-back value seen by decode in the same cycle
  always_comb begin
    if (rs1 == '0)
      rs1_data = '0;
    else if (we && rd == rs1)
      rs1_data = rd_data;
    else
      rs1_data = regs[rs1];
  end

  always_comb begin
    if (rs2 == '0)
      rs2_data = '0;
    else if (we && rd == rs2)
      rs2_data = rd_data;
    else
      rs2_data = regs[rs2];
  end

endmodule

// File: src/alu.sv
/* ALU
   Add, sub, and, or, xor, sll with N, Z, C, V flags */
`timescale 1ns/1ps

module alu
  import pipe_pkg::*;
(
  input  word_t      a,
  input  word_t      b,
  input  alu_op_e    op,
  output word_t      result,
  output alu_flags_t flags
);

  localparam int W = $bits(word_t);

  logic           is_sub;
  word_t          b_eff;
  logic [W:0]     sum;  // Carry in the top bit

  assign is_sub = (op == ALU_SUB);
  assign b_eff  = is_sub ? ~b : b;
  assign sum    = {1'b0, a} + {1'b0, b_eff} + {{W{1'b0}}, is_sub};

  always_comb begin
    case (op)
      ALU_ADD,
      ALU_SUB: result = sum[W-1:0];
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLL: result = a << b[4:0];
      default: result = sum[W-1:0];
    endcase
  end

  assign flags.n = result[W-1];
  assign flags.z = (result == '0);
  // C set means no borrow on sub, i.e. a >= b unsigned
  assign flags.c = (op == ALU_ADD || is_sub) ? sum[W] : 1'b0;
  assign flags.v = (op == ALU_ADD || is_sub) &&
                   (a[W-1] == b_eff[W-1]) && (sum[W-1] != a[W-1]);

endmodule

// File: src/hazard_unit.sv
/* Hazard unit
   Forwarding selects for the execute operands and the load-use stall */
`timescale 1ns/1ps

module hazard_unit
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;
(
  input  instr_u   id_instr,
  input  id_ex_t   id_ex,
  input  ex_mem_t  ex_mem,
  input  mem_wb_t  mem_wb,
  output fwd_sel_e fwd_a,
  output fwd_sel_e fwd_b,
  output logic     stall
);

  reg_idx_t id_rs1;
  reg_idx_t id_rs2;
  logic     load_in_ex;

  // Memory stage wins as it holds the younger value
  function automatic fwd_sel_e pick_source(reg_idx_t src);
    fwd_sel_e sel;
    sel = FWD_NONE;
    if (ex_mem.ctrl.reg_write && ex_mem.rd != '0 && ex_mem.rd == src)
      sel = FWD_MEM;
    else if (mem_wb.ctrl.reg_write && mem_wb.rd != '0 && mem_wb.rd == src)
      sel = FWD_WB;
    return sel;
  endfunction

  assign fwd_a = pick_source(id_ex.rs1);
  assign fwd_b = pick_source(id_ex.rs2);

  assign id_rs1 = id_instr.r.rs1;
  assign id_rs2 = id_instr.r.rs2;

  assign load_in_ex = id_ex.ctrl.mem_to_reg && id_ex.ctrl.reg_write && id_ex.rd != '0;

  // Load data is not ready until write-back
  assign stall = load_in_ex && (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

endmodule

// File: src/rv32i_pipe_cpu.sv
/* RV32I five-stage pipelined core
   PC, stage registers, forwarding muxes, branch resolution and flush */
`timescale 1ns/1ps

module rv32i_pipe_cpu
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output word_t pc,
  input  word_t inst,
  output logic  mem_write,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  word_t mem_rdata
);

  if_id_t     if_id;
  id_ex_t     id_ex;
  ex_mem_t    ex_mem;
  mem_wb_t    mem_wb;
  instr_u     id_instr;
  ctrl_t      id_ctrl;
  word_t      id_imm;
  word_t      rs1_data;
  word_t      rs2_data;
  fwd_sel_e   fwd_a;
  fwd_sel_e   fwd_b;
  logic       stall;
  word_t      fwd_a_val;
  word_t      fwd_b_val;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  alu_flags_t flags;
  logic       branch_cond;
  logic       redirect;
  word_t      mem_fwd_val;
  word_t      wb_val;

  // Fetch
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= RESET_PC;
    else if (redirect)
      pc <= id_ex.pc + id_ex.imm;  // Branch or jal target
    else if (!stall)
      pc <= pc + 4;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      if_id.pc    <= RESET_PC;
      if_id.instr <= NOP_INSTR;
    end
    else if (redirect)
      if_id.instr <= NOP_INSTR;  // Flush fetch slot
    else if (!stall)
    begin
      if_id.pc    <= pc;
      if_id.instr <= inst;
    end
  end

  // Decode slot squashed while execute redirects
  assign id_instr = redirect ? NOP_INSTR : if_id.instr;

  decoder u_decoder (
    .instr (id_instr),
    .ctrl  (id_ctrl),
    .imm   (id_imm)
  );

  regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .we       (mem_wb.ctrl.reg_write),
    .rs1      (id_instr.r.rs1),
    .rs2      (id_instr.r.rs2),
    .rd       (mem_wb.rd),
    .rd_data  (wb_val),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  hazard_unit u_hazard_unit (
    .id_instr (id_instr),
    .id_ex    (id_ex),
    .ex_mem   (ex_mem),
    .mem_wb   (mem_wb),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .stall    (stall)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else
    begin
      id_ex.ctrl     <= stall ? ctrl_t'('0) : id_ctrl;  // Bubble on load-use
      id_ex.funct3   <= id_instr.r.funct3;
      id_ex.rs1      <= id_instr.r.rs1;
      id_ex.rs2      <= id_instr.r.rs2;
      id_ex.rd       <= id_instr.r.rd;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= id_imm;
      id_ex.pc       <= if_id.pc;
    end
  end

  // Execute
  function automatic word_t select_fwd(fwd_sel_e sel, word_t reg_val);
    case (sel)
      FWD_MEM: return mem_fwd_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign fwd_a_val = select_fwd(fwd_a, id_ex.rs1_data);
  assign fwd_b_val = select_fwd(fwd_b, id_ex.rs2_data);
  assign alu_a     = id_ex.ctrl.lui ? '0 : fwd_a_val;
  assign alu_b     = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b_val;

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (id_ex.ctrl.alu_op),
    .result (alu_result),
    .flags  (flags)
  );

  always_comb begin
    case (id_ex.funct3)
      F3_BEQ:  branch_cond = flags.z;
      F3_BNE:  branch_cond = ~flags.z;
      F3_BLT:  branch_cond = (flags.n != flags.v);
      F3_BGE:  branch_cond = (flags.n == flags.v);
      F3_BLTU: branch_cond = ~flags.c;
      F3_BGEU: branch_cond = flags.c;
      default: branch_cond = 1'b0;
    endcase
  end

  assign redirect = (id_ex.ctrl.branch && branch_cond) || id_ex.ctrl.jal;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
    begin
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= fwd_b_val;
      ex_mem.pc         <= id_ex.pc;
    end
  end

  // Memory
  assign mem_write   = ex_mem.ctrl.mem_write;
  assign mem_addr    = ex_mem.alu_result;
  assign mem_wdata   = ex_mem.store_data;
  assign mem_fwd_val = ex_mem.ctrl.jal ? ex_mem.pc + 4 : ex_mem.alu_result;  // Link for jal

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_wb <= '0;
    else
    begin
      mem_wb.ctrl       <= ex_mem.ctrl;
      mem_wb.rd         <= ex_mem.rd;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.rdata      <= mem_rdata;
      mem_wb.pc         <= ex_mem.pc;
    end
  end

  // Write-back
  always_comb begin
    if (mem_wb.ctrl.jal)
      wb_val = mem_wb.pc + 4;
    else if (mem_wb.ctrl.mem_to_reg)
      wb_val = mem_wb.rdata;
    else
      wb_val = mem_wb.alu_result;
  end

endmodule

// File: testbench/clk_gen.sv
/* Testbench clock and reset
   4 ns clock, reset held high for the first 16 rising edges */
`timescale 1ns/1ps

module clk_gen
(
  output logic clk,
  output logic reset
);

  initial
  begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

  always #2 clk = ~clk;  // 4 ns period

endmodule

// File: testbench/cpu_checker.sv
/* Store checker with an RV32I reference model
   Runs the ROM on its own state and compares every mem_write against it */
`timescale 1ns/1ps

module cpu_checker
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;
#(
  parameter int ROM_WORDS = 128,
  parameter int RAM_WORDS = 256
)
(
  input  logic  clk,
  input  logic  reset,
  input  word_t pc,
  input  logic  mem_write,
  input  word_t mem_addr,
  input  word_t mem_wdata,
  input  word_t rom [ROM_WORDS],
  input  logic  report,
  output logic  done,
  output int    err_count
);

  word_t exp_addr [$];
  word_t exp_data [$];
  word_t dmem [RAM_WORDS];
  word_t halt_pc = '1;
  int    seen = 0;
  int    val_errs = 0;
  int    other_errs = 0;
  logic  built = 1'b0;
  logic  pc_checked = 1'b0;
  logic  at_halt = 1'b0;
  logic  reported = 1'b0;

  assign done      = at_halt;  // Core has fetched the halt loop
  assign err_count = val_errs + other_errs;

  // Reference model that steps one instruction at a time up to the halt loop
  function automatic void run_model();
    word_t  x [32];
    word_t  cur;
    word_t  nxt;
    word_t  a;
    word_t  b;
    word_t  ea;
    word_t  res;
    instr_u in;
    logic   halted;
    logic   take;
    for (int i = 0; i < 32; i++)
      x[i] = '0;
    for (int i = 0; i < RAM_WORDS; i++)
      dmem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    cur = RESET_PC;
    halted = 1'b0;
    for (int step = 0; step < 2000 && !halted; step++)
    begin
      in  = rom[cur[8:2]];
      a   = x[in.r.rs1];
      b   = x[in.r.rs2];
      nxt = cur + 32'd4;
      res = '0;
      case (in.r.opcode)
        OP_R, OP_I_ARITH:
        begin
          if (in.r.opcode == OP_I_ARITH)
            b = {{20{in.i.imm[11]}}, in.i.imm};
          case (in.r.funct3)
            3'b000:  res = (in.r.opcode == OP_R && in.r.funct7[5]) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            default: res = a & b;
          endcase
          x[in.r.rd] = res;
        end
        OP_LOAD:
        begin
          ea = a + {{20{in.i.imm[11]}}, in.i.imm};
          x[in.r.rd] = dmem[ea[9:2]];
        end
        OP_STORE:
        begin
          ea = a + {{20{in.s.imm_hi[6]}}, in.s.imm_hi, in.s.imm_lo};
          dmem[ea[9:2]] = b;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        OP_BRANCH:
        begin
          case (in.b.funct3)
            3'b000:  take = (a == b);
            3'b001:  take = (a != b);
            3'b100:  take = ($signed(a) < $signed(b));
            3'b101:  take = ($signed(a) >= $signed(b));
            3'b110:  take = (a < b);
            default: take = (a >= b);
          endcase
          if (take)
            nxt = cur + {{19{in.b.imm12}}, in.b.imm12, in.b.imm11, in.b.imm10_5,
                         in.b.imm4_1, 1'b0};
        end
        OP_LUI: x[in.r.rd] = {in.u.imm31_12, 12'b0};
        OP_JAL:
        begin
          x[in.r.rd] = cur + 32'd4;
          nxt = cur + {{11{in.j.imm20}}, in.j.imm20, in.j.imm19_12, in.j.imm11,
                       in.j.imm10_1, 1'b0};
          halted = (nxt == cur);
        end
        default: ;
      endcase
      x[0] = '0;
      cur  = nxt;
    end
    halt_pc = halted ? cur : '1;
  endfunction

  initial
  begin
    @(negedge reset);
    run_model();
    built = 1'b1;
  end

  always @(negedge clk)
  begin
    if (reset)
    begin
      if (mem_write)
      begin
        $display("Store strobe seen while reset is active");
        other_errs++;
      end
    end
    else if (built)
    begin
      if (!pc_checked)
      begin
        pc_checked = 1'b1;
        if (pc !== RESET_PC)
        begin
          $display("ERR pc: got %h, expected %h", pc, RESET_PC);
          val_errs++;
        end
      end
      if (pc == halt_pc)
        at_halt = 1'b1;
      if (mem_write)
      begin
        if (seen >= exp_addr.size())
        begin
          $display("Extra store to address %h that the program does not make", mem_addr);
          other_errs++;
        end
        else
        begin
          if (mem_addr !== exp_addr[seen])
          begin
            $display("ERR mem_addr: got %h, expected %h", mem_addr, exp_addr[seen]);
            val_errs++;
          end
          if (mem_wdata !== exp_data[seen])
          begin
            $display("ERR mem_wdata: got %h, expected %h", mem_wdata, exp_data[seen]);
            val_errs++;
          end
          seen++;
        end
      end
      if (report && !reported)
      begin
        reported = 1'b1;
        if (seen < exp_addr.size())
        begin
          $display("%0d expected stores never appeared", exp_addr.size() - seen);
          other_errs++;
        end
        $display("Stores checked %0d of %0d, value errors %0d, other errors %0d",
                 seen, exp_addr.size(), val_errs, other_errs);
      end
    end
  end

endmodule

// File: testbench/tb_top.sv
/* Testbench top for the pipelined RV32I core
   Builds a program with random immediates, holds ROM and RAM, limits the run */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_top
  import rv32i_isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int ROM_WORDS = 128;
  localparam int RAM_WORDS = 256;

  logic        clk;
  logic        reset;
  word_t       pc;
  word_t       inst;
  logic        mem_write;
  word_t       mem_addr;
  word_t       mem_wdata;
  word_t       mem_rdata;
  word_t       rom [ROM_WORDS];
  word_t       ram [RAM_WORDS];
  word_t       prog [$];
  logic [11:0] st_off;
  logic        report = 1'b0;
  logic        done;
  int          err_count;
  int          cycles = 0;
  int          limit = 0;

  clk_gen u_clk_gen (.clk(clk), .reset(reset));

  rv32i_pipe_cpu rv32i_pipe_cpu_inst (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  cpu_checker #(.ROM_WORDS(ROM_WORDS), .RAM_WORDS(RAM_WORDS)) u_checker (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .rom       (rom),
    .report    (report),
    .done      (done),
    .err_count (err_count)
  );

  // Single-cycle word-addressed memories
  assign inst      = rom[pc[8:2]];
  assign mem_rdata = ram[mem_addr[9:2]];

  always @(posedge clk)
  begin
    if (mem_write)
      ram[mem_addr[9:2]] <= mem_wdata;
  end

  function automatic word_t reg_reg_instr(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_R};
  endfunction

  function automatic word_t imm_instr(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t store_instr(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t branch_instr(logic [12:0] off, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t jump_instr(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [11:0] rand12();
    word_t r;
    r = $urandom();
    return r[11:0];
  endfunction

  task automatic put(word_t w);
    prog.push_back(w);
  endtask

  // Each store gets its own word above the base in x10
  task automatic store_reg(logic [4:0] rs);
    put(store_instr(st_off, rs, 5'd10));
    st_off = st_off + 12'd4;
  endtask

  task automatic branch_case(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
    put(branch_instr(13'd8, rs1, rs2, f3));
    store_reg(5'd3);  // Skipped when taken
    store_reg(5'd3);
  endtask

  task automatic build_program();
    word_t r;
    st_off = 12'd0;
    put(imm_instr(12'h100, 5'd0, F3_ADD, 5'd10, OP_I_ARITH));
    put(imm_instr(rand12(), 5'd0, F3_ADD, 5'd1, OP_I_ARITH));
    put(imm_instr(rand12(), 5'd0, F3_ADD, 5'd2, OP_I_ARITH));
    put(reg_reg_instr(7'd0, 5'd2, 5'd1, F3_ADD, 5'd3));
    store_reg(5'd3);
    put(reg_reg_instr(F7_SUB, 5'd1, 5'd3, F3_ADD, 5'd4));
    store_reg(5'd4);
    put(reg_reg_instr(7'd0, 5'd2, 5'd4, F3_AND, 5'd5));
    put(reg_reg_instr(7'd0, 5'd1, 5'd5, F3_OR, 5'd6));
    put(reg_reg_instr(7'd0, 5'd3, 5'd6, F3_XOR, 5'd7));
    put(reg_reg_instr(7'd0, 5'd1, 5'd7, F3_SLL, 5'd8));
    store_reg(5'd5);
    store_reg(5'd6);
    store_reg(5'd7);
    store_reg(5'd8);
    put(imm_instr(rand12(), 5'd8, F3_AND, 5'd20, OP_I_ARITH));
    store_reg(5'd20);
    put(imm_instr(rand12(), 5'd20, F3_OR, 5'd21, OP_I_ARITH));
    put(imm_instr(rand12(), 5'd21, F3_XOR, 5'd22, OP_I_ARITH));
    r = $urandom();
    put(imm_instr({7'd0, r[4:0]}, 5'd22, F3_SLL, 5'd23, OP_I_ARITH));
    store_reg(5'd23);
    // Load-use pairs
    put(imm_instr(12'h040, 5'd0, 3'b010, 5'd11, OP_LOAD));
    put(reg_reg_instr(7'd0, 5'd11, 5'd11, F3_ADD, 5'd12));
    store_reg(5'd12);
    put(imm_instr(12'h000, 5'd10, 3'b010, 5'd13, OP_LOAD));
    put(reg_reg_instr(7'd0, 5'd1, 5'd13, F3_ADD, 5'd12));
    store_reg(5'd12);
    put(imm_instr(12'hfff, 5'd0, F3_ADD, 5'd14, OP_I_ARITH));  // -1
    put(imm_instr(12'h001, 5'd0, F3_ADD, 5'd15, OP_I_ARITH));
    branch_case(F3_BEQ, 5'd15, 5'd15);
    branch_case(F3_BEQ, 5'd14, 5'd15);
    branch_case(F3_BNE, 5'd14, 5'd15);
    branch_case(F3_BNE, 5'd15, 5'd15);
    branch_case(F3_BLT, 5'd14, 5'd15);
    branch_case(F3_BLT, 5'd15, 5'd14);
    branch_case(F3_BGE, 5'd15, 5'd14);
    branch_case(F3_BGE, 5'd14, 5'd15);
    branch_case(F3_BLTU, 5'd15, 5'd14);
    branch_case(F3_BLTU, 5'd14, 5'd15);
    branch_case(F3_BGEU, 5'd14, 5'd15);
    branch_case(F3_BGEU, 5'd15, 5'd14);
    put(jump_instr(21'd8, 5'd16));
    store_reg(5'd1);  // Never reached
    store_reg(5'd16);
    r = $urandom();
    put({r[19:0], 5'd17, OP_LUI});
    put(imm_instr(rand12(), 5'd17, F3_ADD, 5'd17, OP_I_ARITH));
    store_reg(5'd17);
    put(imm_instr(rand12(), 5'd0, F3_ADD, 5'd0, OP_I_ARITH));
    store_reg(5'd0);
    put(jump_instr(21'd0, 5'd0));  // Halt loop
  endtask

  initial
  begin
    void'($urandom(32'hd154_0ad4));
    build_program();
    for (int i = 0; i < ROM_WORDS; i++)
      rom[i] = (i < prog.size()) ? prog[i] : `CPU_NOP;
    for (int i = 0; i < RAM_WORDS; i++)
      ram[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    limit = 4 * prog.size() + 16 + 50;
    while (!done)
      @(posedge clk);
    repeat (8) @(posedge clk);  // Catch stray stores
    report <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    if (err_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+src
src/rv32i_isa_pkg.sv
src/pipe_pkg.sv
src/decoder.sv
src/regfile.sv
src/alu.sv
src/hazard_unit.sv
src/rv32i_pipe_cpu.sv
testbench/clk_gen.sv
testbench/cpu_checker.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

SRCS := $(wildcard src/*.sv src/*.svh testbench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) compile.f
	$(VERILATOR) --binary --timing -f compile.f --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
